/* common/rv32_isa_pkg.sv */
// Instruction-side types for the RV32 memory stage: memory ops and pipeline payloads.
`default_nettype none

package rv32_isa_pkg;

    localparam int XLEN = 32; // Data word width.

    // Memory operation carried by a decoded instruction.
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB,
        MEM_LH,
        MEM_LW,
        MEM_LBU,
        MEM_LHU,
        MEM_SB,
        MEM_SH,
        MEM_SW
    } mem_op_t;

    // Fields of the decoded instruction the memory stage needs.
    typedef struct packed {
        mem_op_t    mem_op;
        logic [4:0] rd;
    } decoded_instr_t;

    // Execute-to-memory payload.
    typedef struct packed {
        decoded_instr_t  decoded_instr;
        logic [XLEN-1:0] mem_addr;  // Effective address.
        logic [XLEN-1:0] wb_result; // ALU result or store data.
    } exec_buffer_data_t;

    // Memory-to-writeback payload.
    typedef struct packed {
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } writeback_t;

endpackage

`default_nettype wire

/* common/rv32_mem_pkg.sv */
// Data memory side types and sizes for the RV32 memory stage.
`default_nettype none

package rv32_mem_pkg;

    // Memory geometry.
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = 8;  // Word address width, log2 of MEM_WORDS.

    // Request from the load/store unit.
    // Store data arrives already replicated into its byte lanes.
    typedef struct packed {
        logic [rv32_isa_pkg::XLEN-1:0] addr;
        rv32_isa_pkg::mem_op_t         op;
        logic [rv32_isa_pkg::XLEN-1:0] data;
    } memory_request_t;

    // Response back to the load/store unit.
    // Ready is a level, high for one cycle per access.
    typedef struct packed {
        logic [rv32_isa_pkg::XLEN-1:0] data;
        logic                          ready;
    } memory_response_t;

endpackage

`default_nettype wire

/* hdl/rv32_stage_reg.sv */
// Pipeline stage register holding one valid-tagged payload of any packed type.
`timescale 1ns/100ps
`default_nettype none

module rv32_stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     advance,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // Bubbles load an all-zero payload so downstream sees a no-op.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else if (advance) begin
            out_valid <= in_valid;
            if (in_valid) begin
                out_data <= in_data;
            end else begin
                out_data <= '0;
            end
        end
    end

    // An empty stage must look like MEM_NONE to the LSU.
    a_bubble_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        !out_valid |-> (out_data == '0)
    );

endmodule

`default_nettype wire

/* lsu/rv32_load_store_unit.sv */
// Load/store unit: forms memory requests, aligns and extends load data, builds write-back.
`timescale 1ns/100ps
`default_nettype none

module rv32_load_store_unit (
    input  rv32_isa_pkg::exec_buffer_data_t exec_data,
    output rv32_mem_pkg::memory_response_t  response,
    output rv32_isa_pkg::writeback_t        result,
    output rv32_mem_pkg::memory_request_t   data_request,
    input  rv32_mem_pkg::memory_response_t  data_response
);

    import rv32_isa_pkg::*;
    import rv32_mem_pkg::*;

    mem_op_t         op;
    logic [1:0]      offset;
    logic [7:0]      byte_lane;
    logic [15:0]     half_lane;
    logic [XLEN-1:0] load_data;
    logic            is_load;

    assign op     = exec_data.decoded_instr.mem_op;
    assign offset = exec_data.mem_addr[1:0];

    // Request side. Store data goes out replicated across lanes.
    always_comb begin
        data_request.addr = exec_data.mem_addr;
        data_request.op   = op;
        case (op)
            MEM_SB:  data_request.data = {4{exec_data.wb_result[7:0]}};
            MEM_SH:  data_request.data = {2{exec_data.wb_result[15:0]}};
            default: data_request.data = exec_data.wb_result;
        endcase
    end

    // Lane selection.
    always_comb begin
        case (offset)
            2'd0:    byte_lane = data_response.data[7:0];
            2'd1:    byte_lane = data_response.data[15:8];
            2'd2:    byte_lane = data_response.data[23:16];
            default: byte_lane = data_response.data[31:24];
        endcase
        case (offset)
            2'd0:    half_lane = data_response.data[15:0];
            2'd2:    half_lane = data_response.data[31:16];
            default: half_lane = '0; // Misaligned reads as zero.
        endcase
    end

    // Extension and ready. Non-memory ops never wait.
    always_comb begin
        load_data      = '0;
        is_load        = 1'b1;
        response.ready = data_response.ready;
        case (op)
            MEM_LB:  load_data = {{24{byte_lane[7]}}, byte_lane};
            MEM_LBU: load_data = {24'd0, byte_lane};
            MEM_LH:  load_data = {{16{half_lane[15]}}, half_lane};
            MEM_LHU: load_data = {16'd0, half_lane};
            MEM_LW: begin
                if (offset == 2'd0) begin
                    load_data = data_response.data;
                end
            end
            MEM_SB, MEM_SH, MEM_SW: begin
                is_load = 1'b0; // Stores still wait on memory.
            end
            default: begin
                is_load        = 1'b0;
                response.ready = 1'b1;
            end
        endcase
        response.data = load_data;
    end

    // Write-back value.
    always_comb begin
        result.rd = exec_data.decoded_instr.rd;
        if (is_load) begin
            result.data = load_data;
        end else begin
            result.data = exec_data.wb_result;
        end
    end

endmodule

`default_nettype wire

/* hdl/rv32_data_memory.sv */
// Word-organized data RAM with byte-lane stores and a one-cycle registered response.
`timescale 1ns/100ps
`default_nettype none

module rv32_data_memory (
    input  logic                           clk,
    input  logic                           rst_n,
    input  rv32_mem_pkg::memory_request_t  data_request,
    output rv32_mem_pkg::memory_response_t data_response
);

    import rv32_isa_pkg::*;
    import rv32_mem_pkg::*;

    logic [XLEN-1:0]   mem [MEM_WORDS];
    logic [XLEN-1:0]   rdata_q;
    logic              pending_q;
    logic              start;
    logic [MEM_AW-1:0] word_idx;
    logic [1:0]        offset;
    logic [3:0]        byte_en;

    assign word_idx = data_request.addr[MEM_AW+1:2];
    assign offset   = data_request.addr[1:0];
    assign start    = (data_request.op != MEM_NONE) && !pending_q;

    // Lane enables. Misaligned SH and SW write nothing.
    always_comb begin
        byte_en = 4'b0000;
        case (data_request.op)
            MEM_SB: byte_en = 4'b0001 << offset;
            MEM_SH: begin
                if (offset == 2'd0) begin
                    byte_en = 4'b0011;
                end else if (offset == 2'd2) begin
                    byte_en = 4'b1100;
                end
            end
            MEM_SW: begin
                if (offset == 2'd0) begin
                    byte_en = 4'b1111;
                end
            end
            default: byte_en = 4'b0000;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= start; // Clears the cycle after an access.
        end
    end

    // Read and write happen on the starting edge.
    always_ff @(posedge clk) begin
        if (start) begin
            rdata_q <= mem[word_idx];
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[word_idx][8*i +: 8] <= data_request.data[8*i +: 8];
                end
            end
        end
    end

    assign data_response.data  = rdata_q;
    assign data_response.ready = pending_q;

    // Ready is a single-cycle pulse per access.
    a_ready_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        data_response.ready |=> !data_response.ready
    );

    // The execute register must hold the request until ready.
    a_op_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        pending_q |-> $stable(data_request.op)
    );

endmodule

`default_nettype wire

/* hdl/rv32_mem_stage.sv */
// RV32 memory stage: execute register, load/store unit, data memory and write-back register.
`timescale 1ns/100ps
`default_nettype none

module rv32_mem_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  rv32_isa_pkg::exec_buffer_data_t in_data,
    output logic                            in_ready,
    output logic                            wb_valid,
    output rv32_isa_pkg::writeback_t        wb_data
);

    import rv32_isa_pkg::*;
    import rv32_mem_pkg::*;

    exec_buffer_data_t exec_q;
    logic              exec_valid_q;
    memory_request_t   data_request;
    memory_response_t  data_response;
    memory_response_t  response;
    writeback_t        result;

    assign in_ready = response.ready; // Both registers advance on this.

    rv32_stage_reg #(
        .payload_t (exec_buffer_data_t)
    ) u_exec_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (response.ready),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (exec_valid_q),
        .out_data  (exec_q)
    );

    rv32_load_store_unit u_lsu (
        .exec_data     (exec_q),
        .response      (response),
        .result        (result),
        .data_request  (data_request),
        .data_response (data_response)
    );

    rv32_data_memory u_dmem (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_request  (data_request),
        .data_response (data_response)
    );

    rv32_stage_reg #(
        .payload_t (writeback_t)
    ) u_wb_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (response.ready),
        .in_valid  (exec_valid_q),
        .in_data   (result),
        .out_valid (wb_valid),
        .out_data  (wb_data)
    );

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
// Testbench clock and reset source: 4 ns clock, reset held low for four cycles.
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1; // Released just after an edge.
    end

endmodule

`default_nettype wire

/* dv/tb_rv32_mem_stage.sv */
// Directed testbench for the RV32 memory stage, checked against a byte-level memory model.
`timescale 1ns/100ps
`default_nettype none

module tb_rv32_mem_stage;

    import rv32_isa_pkg::*;
    import rv32_mem_pkg::*;

    localparam int N_RANDOM   = 200;
    localparam int N_OPS      = MEM_WORDS + 64 + N_RANDOM; // Directed ops rounded up.
    localparam int MAX_CYCLES = N_OPS * 3 + 200;

    typedef struct packed {
        writeback_t  wb;
        logic [31:0] edge_no; // Edge after which the result shows.
    } expect_t;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    exec_buffer_data_t in_data;
    logic              in_ready;
    logic              wb_valid;
    writeback_t        wb_data;

    logic [7:0]  model_mem [MEM_WORDS*4];
    expect_t     expect_q [$];
    logic [31:0] cycle_cnt = '0;
    logic        ready_prev = 1'b0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          seed = 32'h3bf68baa;

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv32_mem_stage uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_ready (in_ready),
        .wb_valid (wb_valid),
        .wb_data  (wb_data)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // A new write-back is present only if the stage advanced last cycle.
    always @(negedge clk) begin
        if (!rst_n) begin
            ready_prev = 1'b0;
        end else begin
            if (ready_prev && wb_valid) begin
                check_writeback();
            end
            ready_prev = in_ready;
        end
    end

    function automatic logic [7:0] byte_at(input logic [MEM_AW-1:0] word, input logic [1:0] lane);
        return model_mem[{word, lane}];
    endfunction

    function automatic logic [XLEN-1:0] word_addr(input logic [MEM_AW-1:0] idx);
        return {{(XLEN-MEM_AW-2){1'b0}}, idx, 2'b00};
    endfunction

    function automatic logic [XLEN-1:0] fill_word(input logic [MEM_AW-1:0] idx);
        return {idx ^ 8'h3c, ~idx, idx + 8'h5a, idx};
    endfunction

    function automatic logic is_load_op(input mem_op_t op);
        return op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
    endfunction

    function automatic logic [XLEN-1:0] model_load(input mem_op_t op, input logic [XLEN-1:0] addr);
        logic [MEM_AW-1:0] word;
        logic [1:0]        off;
        logic [7:0]        b;
        logic [15:0]       h;
        logic [XLEN-1:0]   w;
        word = addr[MEM_AW+1:2];
        off  = addr[1:0];
        b    = byte_at(word, off);
        h    = off[0] ? 16'h0000 : {byte_at(word, {off[1], 1'b1}), byte_at(word, {off[1], 1'b0})};
        w    = '0;
        if (off == 2'd0) begin
            w = {byte_at(word, 2'd3), byte_at(word, 2'd2), byte_at(word, 2'd1), byte_at(word, 2'd0)};
        end
        case (op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'd0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'd0, h};
            default: return w;
        endcase
    endfunction

    function automatic void apply_store(input mem_op_t op, input logic [XLEN-1:0] addr,
                                        input logic [XLEN-1:0] value);
        logic [MEM_AW-1:0] word;
        logic [1:0]        off;
        word = addr[MEM_AW+1:2];
        off  = addr[1:0];
        case (op)
            MEM_SB: model_mem[{word, off}] = value[7:0];
            MEM_SH: begin
                if (!off[0]) begin
                    model_mem[{word, off[1], 1'b0}] = value[7:0];
                    model_mem[{word, off[1], 1'b1}] = value[15:8];
                end
            end
            MEM_SW: begin
                if (off == 2'd0) begin
                    for (int i = 0; i < 4; i++) begin
                        model_mem[{word, i[1:0]}] = value[8*i +: 8];
                    end
                end
            end
            default: ;
        endcase
    endfunction

    task automatic check_writeback();
        expect_t e;
        assert (expect_q.size() != 0) else begin
            $display("A write-back appeared with no operation outstanding");
            other_errors++;
        end
        if (expect_q.size() != 0) begin
            e = expect_q.pop_front();
            assert (wb_data.rd == e.wb.rd) else begin
                $display("** Error: wb_data.rd = %h, expected %h", wb_data.rd, e.wb.rd);
                value_errors++;
            end
            assert (wb_data.data == e.wb.data) else begin
                $display("** Error: wb_data.data = %h, expected %h", wb_data.data, e.wb.data);
                value_errors++;
            end
            assert (cycle_cnt == e.edge_no) else begin
                $display("** Error: write-back edge = %h, expected %h", cycle_cnt, e.edge_no);
                value_errors++;
            end
        end
    endtask

    // Drives one op until accepted and queues its expected write-back.
    task automatic issue_op(input mem_op_t op, input logic [4:0] rd,
                            input logic [XLEN-1:0] addr, input logic [XLEN-1:0] value);
        decoded_instr_t    instr;
        exec_buffer_data_t item;
        expect_t           e;
        logic              ready_now;
        logic              is_mem;
        instr.mem_op   = op;
        instr.rd       = rd;
        item.decoded_instr = instr;
        item.mem_addr  = addr;
        item.wb_result = value;
        is_mem   = (op != MEM_NONE);
        e.wb.rd  = rd;
        e.wb.data = is_load_op(op) ? model_load(op, addr) : value;
        apply_store(op, addr, value);
        in_data  = item;
        in_valid = 1'b1;
        ready_now = 1'b0;
        while (!ready_now) begin
            ready_now = in_ready;
            @(posedge clk);
            #1;
        end
        in_valid  = 1'b0;
        in_data   = '0;
        e.edge_no = cycle_cnt + (is_mem ? 32'd2 : 32'd1);
        expect_q.push_back(e);
        if (is_mem) begin
            assert (in_ready == 1'b0) else begin
                $display("** Error: in_ready = %h, expected 0 after memory op", in_ready);
                value_errors++;
            end
            @(posedge clk);
            #1;
            assert (in_ready == 1'b1) else begin
                $display("** Error: in_ready = %h, expected 1 on memory ready", in_ready);
                value_errors++;
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic test_reset_and_passthrough();
        assert ($bits(memory_request_t) == 68 && $bits(memory_response_t) == 33
                && $bits(exec_buffer_data_t) == 73 && $bits(writeback_t) == 37) else begin
            $display("Packed payload widths do not match the 68/33/73/37 bit layout");
            other_errors++;
        end
        assert (wb_valid == 1'b0) else begin
            $display("** Error: wb_valid = %h, expected 0 after reset", wb_valid);
            value_errors++;
        end
        assert (in_ready == 1'b1) else begin
            $display("** Error: in_ready = %h, expected 1 after reset", in_ready);
            value_errors++;
        end
        issue_op(MEM_NONE, 5'd5, 32'h0000_0123, 32'hdead_beef);
        issue_op(MEM_NONE, 5'd31, 32'h0000_0000, 32'h0000_0001);
        issue_op(MEM_NONE, 5'd0, 32'hffff_fffc, 32'h8000_0000);
    endtask

    task automatic init_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            issue_op(MEM_SW, 5'd1, word_addr(i[MEM_AW-1:0]), fill_word(i[MEM_AW-1:0]));
        end
    endtask

    task automatic test_word_access();
        logic [XLEN-1:0] addrs [5];
        addrs = '{32'h000, 32'h004, 32'h1f0, 32'h3fc, 32'h7fc}; // Last one aliases 0x3fc.
        for (int i = 0; i < 5; i++) begin
            issue_op(MEM_SW, 5'(i + 8), addrs[i], {addrs[i][15:0], 16'hc0de});
        end
        for (int i = 0; i < 5; i++) begin
            issue_op(MEM_LW, 5'(i + 16), addrs[i], 32'hffff_ffff);
        end
    endtask

    task automatic test_byte_lanes();
        logic [7:0] lanes [4];
        lanes = '{8'h81, 8'h7e, 8'hf0, 8'h0f};
        for (int i = 0; i < 4; i++) begin
            issue_op(MEM_SB, 5'd2, {30'h20, i[1:0]}, {24'ha5a5a5, lanes[i]});
            issue_op(MEM_LW, 5'd3, {30'h20, 2'b00}, '0); // Other lanes untouched.
        end
        for (int i = 0; i < 4; i++) begin
            issue_op(MEM_LB, 5'd4, {30'h20, i[1:0]}, '0);
            issue_op(MEM_LBU, 5'd5, {30'h20, i[1:0]}, '0);
        end
    endtask

    task automatic test_halfwords();
        issue_op(MEM_SH, 5'd6, 32'h0c0, 32'h1234_8001);
        issue_op(MEM_SH, 5'd6, 32'h0c2, 32'h5678_7ffe);
        for (int i = 0; i < 4; i++) begin
            issue_op(MEM_LH, 5'd7, {30'h30, i[1:0]}, '0);
            issue_op(MEM_LHU, 5'd8, {30'h30, i[1:0]}, '0);
        end
        issue_op(MEM_SH, 5'd9, 32'h0c5, 32'hffff_ffff);
        issue_op(MEM_SH, 5'd9, 32'h0c7, 32'hffff_ffff);
        issue_op(MEM_SW, 5'd9, 32'h0c5, 32'hffff_ffff);
        issue_op(MEM_SW, 5'd9, 32'h0c6, 32'hffff_ffff);
        issue_op(MEM_SW, 5'd9, 32'h0c7, 32'hffff_ffff);
        issue_op(MEM_LW, 5'd10, 32'h0c4, '0);
        issue_op(MEM_LW, 5'd10, 32'h0c6, '0);
    endtask

    task automatic test_random_stream();
        logic [XLEN-1:0] r;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] value;
        for (int n = 0; n < N_RANDOM; n++) begin
            r     = $random(seed);
            addr  = $random(seed);
            value = $random(seed);
            issue_op(mem_op_t'(r[3:0] % 4'd9), r[8:4], addr, value);
            if (r[10:9] == 2'b11) begin
                idle(int'(r[11]) + 1);
            end
        end
    endtask

    initial begin
        in_valid = 1'b0;
        in_data  = '0;
        @(posedge rst_n);
        @(posedge clk);
        #1;
        test_reset_and_passthrough();
        init_memory();
        test_word_access();
        test_byte_lanes();
        test_halfwords();
        test_random_stream();
        while (expect_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk); // Catch stray write-backs.
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
common/rv32_isa_pkg.sv
common/rv32_mem_pkg.sv
hdl/rv32_stage_reg.sv
lsu/rv32_load_store_unit.sv
hdl/rv32_data_memory.sv
hdl/rv32_mem_stage.sv
dv/tb_clock_gen.sv
dv/tb_rv32_mem_stage.sv

/* Makefile */
# Verilator build and run for the RV32 memory stage.

VERILATOR ?= verilator
TOP       ?= tb_rv32_mem_stage
RTL_TOP   ?= rv32_mem_stage
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
